// ==== arithEncoder.f ====
hdl/arithCodePkg.sv
hdl/seqDivider.sv
hdl/subintervalCalc.sv
hdl/bitPacker.sv
hdl/encoderControl.sv
hdl/arithEncoder.sv
testbench/tbArithEncoder.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tbArithEncoder -f arithEncoder.f
./obj_dir/VtbArithEncoder > sim.log 2>&1 || true
cat sim.log
if grep -qx "RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// ==== testbench/tbArithEncoder.sv ====
// three messages at PRECISION 16 checked against an integer model; the first error ends the run
module tbArithEncoder;
    import arithCodePkg::*;

    localparam int precision = 16;
    localparam int longLen = 60;
    localparam int shortLen = 20;
    localparam int totalSymbols = 1 + (longLen + 1) + (shortLen + 1);
    localparam int watchdogCycles = 2000 * totalSymbols + 10000;
    localparam longint whole = longint'(1) << (precision - 1);
    localparam longint half = longint'(1) << (precision - 2);
    localparam longint quarter = longint'(1) << (precision - 3);
    localparam longint threeQuarters = 3 * quarter;
    localparam longint mask = (longint'(1) << precision) - 1;

    logic       clk;
    logic       rstn;
    logic       start;
    symbolT     symbol;
    logic       symbolProvided;
    logic       readSuccess;
    logic       idle;
    logic       symbolRequested;
    logic       resultReady;
    logic [2:0] validOutputBytes;
    wordT       out;

    logic [15:0] lfsrState = 16'd14780;
    bit          useDelays;
    symbolT      msgSymbols[$];       // whole message with EOF last
    symbolT      pendingSymbols[$];   // symbols still owed to the encoder
    wordT        expWordQ[$];
    logic [2:0]  expBytesQ[$];

    arithEncoder #(.PRECISION(precision)) dut (
        .clk(clk), .rstn(rstn), .start(start), .symbol(symbol),
        .symbolProvided(symbolProvided), .readSuccess(readSuccess), .idle(idle),
        .symbolRequested(symbolRequested), .resultReady(resultReady),
        .validOutputBytes(validOutputBytes), .out(out)
    );

    always #20 clk = ~clk;

    task automatic stopRun();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        stopRun();
    endtask

    task automatic reportProblem(input string text);
        $display("Error at time %0t: %s", $time, text);
        stopRun();
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic bit nextRandomBit();
        bit lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic int randomBits(input int count);
        int value;
        value = 0;
        repeat (count) value = (value << 1) | int'(nextRandomBit());
        return value;
    endfunction

    function automatic symbolT randomSymbol();
        int value;
        value = randomBits(SYM_W);
        while (value == int'(EOF_SYMBOL)) value = randomBits(SYM_W);    // EOF only at the end
        return symbolT'(value);
    endfunction

    // integer model of interval narrowing, rescaling and LSB-first packing
    task automatic buildExpected();
        longint lo;
        longint hi;
        longint wd;
        longint hiOff;
        longint loOff;
        int     pend;
        bit     bits[$];
        bit     done;
        bit     last;
        wordT   word;
        int     idx;
        lo = 0;
        hi = whole;
        wd = whole;
        pend = 0;
        foreach (msgSymbols[i]) begin
            hiOff = wd * longint'(CUM_HIGH[msgSymbols[i]]) / TOTAL_FREQ;
            loOff = wd * longint'(CUM_LOW[msgSymbols[i]]) / TOTAL_FREQ;
            hi = lo + hiOff;
            lo = lo + loOff;
            done = 1'b0;
            while (!done) begin
                if (hi < half) begin
                    bits.push_back(1'b0);
                    repeat (pend) bits.push_back(1'b1);
                    pend = 0;
                    lo = (lo << 1) & mask;
                    hi = (hi << 1) & mask;
                end else if (lo > half) begin
                    bits.push_back(1'b1);
                    repeat (pend) bits.push_back(1'b0);
                    pend = 0;
                    lo = ((lo - half) << 1) & mask;
                    hi = ((hi - half) << 1) & mask;
                end else if (lo > quarter && hi < threeQuarters) begin
                    pend = pend + 1;
                    lo = ((lo - quarter) << 1) & mask;
                    hi = ((hi - quarter) << 1) & mask;
                end else if (msgSymbols[i] == EOF_SYMBOL) begin
                    pend = pend + 1;
                    last = (lo > quarter);
                    bits.push_back(last);
                    repeat (pend) bits.push_back(!last);
                    pend = 0;
                    done = 1'b1;
                end else begin
                    wd = hi - lo;
                    done = 1'b1;
                end
            end
        end
        word = '0;
        idx = 0;
        foreach (bits[i]) begin
            word[idx] = bits[i];
            idx = idx + 1;
            if (idx == WORD_W) begin
                expWordQ.push_back(word);
                expBytesQ.push_back(3'd4);
                word = '0;
                idx = 0;
            end
        end
        if (idx != 0) begin    // partial word rounded up to bytes
            expWordQ.push_back(word);
            expBytesQ.push_back(3'((idx + 7) / 8));
        end
    endtask

    task automatic encodeMessage(input int numSymbols, input bit withDelays);
        useDelays = withDelays;
        msgSymbols.delete();
        repeat (numSymbols) msgSymbols.push_back(randomSymbol());
        msgSymbols.push_back(EOF_SYMBOL);
        buildExpected();
        for (int i = 1; i < msgSymbols.size(); i++) begin
            pendingSymbols.push_back(msgSymbols[i]);
        end
        @(posedge clk);
        symbol <= msgSymbols[0];    // first symbol rides on start
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!(idle && expWordQ.size() == 0 && !resultReady && !readSuccess)) begin
            @(negedge clk);
        end
        assert (pendingSymbols.size() == 0)
            else reportProblem("the encoder went idle before taking every symbol");
    endtask

    initial begin : symbolSource
        int delay;
        forever begin
            @(negedge clk);
            if (rstn && symbolRequested) begin
                assert (pendingSymbols.size() != 0)
                    else reportProblem(
                        "the encoder asked for a symbol after the end of the message");
                delay = useDelays ? randomBits(3) : 0;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                symbol         <= pendingSymbols.pop_front();
                symbolProvided <= 1'b1;
                @(negedge clk);
                while (symbolRequested) @(negedge clk);
                @(posedge clk);
                symbolProvided <= 1'b0;
            end
        end
    end

    initial begin : wordReader
        int         delay;
        wordT       expWord;
        logic [2:0] expBytes;
        forever begin
            @(negedge clk);
            if (rstn && resultReady) begin
                assert (expWordQ.size() != 0)
                    else reportProblem("the DUT presented a word that the model does not expect");
                expWord  = expWordQ.pop_front();
                expBytes = expBytesQ.pop_front();
                assert (out == expWord) else reportMismatch("out", expWord, out);
                assert (validOutputBytes == expBytes)
                    else reportMismatch("validOutputBytes", 32'(expBytes), 32'(validOutputBytes));
                delay = useDelays ? randomBits(3) : 0;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                readSuccess <= 1'b1;
                @(negedge clk);
                while (resultReady) @(negedge clk);
                delay = useDelays ? randomBits(3) : 0;    // packer stays stalled meanwhile
                repeat (delay) @(posedge clk);
                @(posedge clk);
                readSuccess <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rstn) begin
            assert (!(idle && symbolRequested))
                else reportProblem("symbolRequested is high while the encoder is idle");
        end
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        reportProblem("timeout, the encoder did not finish all messages in time");
    end

    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        start          = 1'b0;
        symbol         = '0;
        symbolProvided = 1'b0;
        readSuccess    = 1'b0;
        useDelays      = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (idle == 1'b1) else reportMismatch("idle", 32'd1, 32'(idle));
        assert (resultReady == 1'b0) else reportMismatch("resultReady", 32'd0, 32'(resultReady));
        assert (symbolRequested == 1'b0)
            else reportMismatch("symbolRequested", 32'd0, 32'(symbolRequested));
        encodeMessage(0, 1'b0);          // EOF alone
        encodeMessage(longLen, 1'b1);    // random handshake delays
        encodeMessage(shortLen, 1'b0);   // fresh interval after idle
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== hdl/arithEncoder.sv ====
// arithmetic encoder top; PRECISION must keep quarter at least 4x TOTAL_FREQ, words are LSB first
module arithEncoder #(
    parameter int PRECISION = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  arithCodePkg::symbolT symbol,
    input  logic                 symbolProvided,
    input  logic                 readSuccess,
    output logic                 idle,
    output logic                 symbolRequested,
    output logic                 resultReady,
    output logic [2:0]           validOutputBytes,
    output arithCodePkg::wordT   out
);
    import arithCodePkg::*;

    logic                 calcStart;
    logic                 calcDone;
    logic [PRECISION-1:0] width;
    logic [PRECISION-1:0] lowOffset;
    logic [PRECISION-1:0] highOffset;
    symbolT               curSymbol;
    logic                 bitValid;
    logic                 bitValue;
    logic                 flush;
    logic                 packBusy;

    encoderControl #(.PRECISION(PRECISION)) control (
        .clk(clk), .rstn(rstn), .start(start), .symbol(symbol),
        .symbolProvided(symbolProvided), .idle(idle), .symbolRequested(symbolRequested),
        .calcStart(calcStart), .low(), .width(width), .curSymbol(curSymbol),
        .lowOffset(lowOffset), .highOffset(highOffset), .calcDone(calcDone),
        .bitValid(bitValid), .bitValue(bitValue), .flush(flush), .packBusy(packBusy)
    );

    subintervalCalc #(.PRECISION(PRECISION)) subinterval (
        .clk(clk), .rstn(rstn), .calcStart(calcStart), .width(width),
        .curSymbol(curSymbol), .lowOffset(lowOffset), .highOffset(highOffset),
        .calcDone(calcDone)
    );

    bitPacker packer (
        .clk(clk), .rstn(rstn), .bitValid(bitValid), .bitValue(bitValue), .flush(flush),
        .packBusy(packBusy), .resultReady(resultReady), .readSuccess(readSuccess),
        .out(out), .validOutputBytes(validOutputBytes)
    );

endmodule

// ==== hdl/encoderControl.sv ====
// interval FSM; emits bits only while packBusy is low, first symbol is taken with start in idle
module encoderControl #(
    parameter int PRECISION = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  arithCodePkg::symbolT symbol,
    input  logic                 symbolProvided,
    output logic                 idle,
    output logic                 symbolRequested,
    output logic                 calcStart,
    output logic [PRECISION-1:0] low,
    output logic [PRECISION-1:0] width,
    output arithCodePkg::symbolT curSymbol,
    input  logic [PRECISION-1:0] lowOffset,
    input  logic [PRECISION-1:0] highOffset,
    input  logic                 calcDone,
    output logic                 bitValid,
    output logic                 bitValue,
    output logic                 flush,
    input  logic                 packBusy
);
    import arithCodePkg::*;

    localparam int pendingWidth = pendingW(PRECISION);
    localparam logic [PRECISION-1:0] whole = {1'b1, {(PRECISION-1){1'b0}}};
    localparam logic [PRECISION-1:0] half = {2'b01, {(PRECISION-2){1'b0}}};
    localparam logic [PRECISION-1:0] quarter = {3'b001, {(PRECISION-3){1'b0}}};
    localparam logic [PRECISION-1:0] threeQuarters = {3'b011, {(PRECISION-3){1'b0}}};

    typedef enum logic [2:0] {
        stIdle,
        stCalc,
        stRescale,
        stPending,
        stSymWait,
        stSymRelease,
        stFlush
    } stateT;

    stateT                   state;
    logic [PRECISION-1:0]    high;
    logic [pendingWidth-1:0] pending;
    logic                    pendValue;    // value of the bits still owed
    logic                    finalBits;    // pending run closes the message
    logic                    goLeft;
    logic                    goRight;
    logic                    goMiddle;

    assign goLeft   = high < half;
    assign goRight  = low > half;
    assign goMiddle = (low > quarter) && (high < threeQuarters);
    assign idle     = (state == stIdle);

    always_comb begin
        bitValid = 1'b0;
        bitValue = 1'b0;
        flush    = 1'b0;
        if (!packBusy) begin
            case (state)
                stRescale: begin
                    if (goLeft || goRight) begin
                        bitValid = 1'b1;
                        bitValue = !goLeft;
                    end else if (!goMiddle && curSymbol == EOF_SYMBOL) begin
                        bitValid = 1'b1;
                        bitValue = (low > quarter);    // closing bit picks the quarter
                    end
                end
                stPending: begin
                    bitValid = 1'b1;
                    bitValue = pendValue;
                end
                stFlush: flush = 1'b1;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state           <= stIdle;
            symbolRequested <= 1'b0;
            calcStart       <= 1'b0;
        end else begin
            calcStart <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        curSymbol <= symbol;
                        low       <= '0;
                        high      <= whole;
                        width     <= whole;
                        pending   <= '0;
                        finalBits <= 1'b0;
                        calcStart <= 1'b1;
                        state     <= stCalc;
                    end
                end
                stCalc: begin
                    if (calcDone) begin
                        high  <= low + highOffset;    // both bounds from the old low
                        low   <= low + lowOffset;
                        state <= stRescale;
                    end
                end
                stRescale: begin
                    if (goLeft || goRight) begin
                        if (!packBusy) begin
                            pendValue <= goLeft;
                            if (goLeft) begin
                                low  <= low << 1;
                                high <= high << 1;
                            end else begin
                                low  <= (low - half) << 1;
                                high <= (high - half) << 1;
                            end
                            if (pending != '0) begin
                                state <= stPending;
                            end
                        end
                    end else if (goMiddle) begin
                        low     <= (low - quarter) << 1;
                        high    <= (high - quarter) << 1;
                        pending <= pending + 1'b1;
                    end else if (curSymbol == EOF_SYMBOL) begin
                        if (!packBusy) begin
                            pendValue <= (low <= quarter);
                            pending   <= pending + 1'b1;
                            finalBits <= 1'b1;
                            state     <= stPending;
                        end
                    end else begin
                        width           <= high - low;
                        symbolRequested <= 1'b1;
                        state           <= stSymWait;
                    end
                end
                stPending: begin
                    if (!packBusy) begin
                        pending <= pending - 1'b1;
                        if (pending == pendingWidth'(1)) begin
                            state <= finalBits ? stFlush : stRescale;
                        end
                    end
                end
                stSymWait: begin
                    if (symbolProvided) begin
                        curSymbol       <= symbol;
                        symbolRequested <= 1'b0;
                        state           <= stSymRelease;
                    end
                end
                stSymRelease: begin
                    if (!symbolProvided) begin    // source has let go
                        calcStart <= 1'b1;
                        state     <= stCalc;
                    end
                end
                stFlush: begin
                    if (!packBusy) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== hdl/bitPacker.sv ====
// LSB-first packing into 32-bit words; validOutputBytes is sized for a 32-bit word only
module bitPacker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               bitValid,
    input  logic               bitValue,
    input  logic               flush,
    output logic               packBusy,
    output logic               resultReady,
    input  logic               readSuccess,
    output arithCodePkg::wordT out,
    output logic [2:0]         validOutputBytes
);
    import arithCodePkg::*;

    localparam int IDX_W = $clog2(WORD_W);

    typedef enum logic [1:0] {
        stCollect,
        stPresent,
        stRelease
    } stateT;

    stateT            state;
    logic [IDX_W-1:0] bitIndex;

    assign packBusy = (state != stCollect);    // held until readSuccess falls

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state            <= stCollect;
            bitIndex         <= '0;
            resultReady      <= 1'b0;
            out              <= '0;
            validOutputBytes <= '0;
        end else begin
            case (state)
                stCollect: begin
                    if (bitValid) begin
                        out[bitIndex] <= bitValue;
                        bitIndex      <= bitIndex + 1'b1;
                        if (bitIndex == IDX_W'(WORD_W - 1)) begin
                            validOutputBytes <= 3'(WORD_W / 8);
                            resultReady      <= 1'b1;
                            state            <= stPresent;
                        end
                    end else if (flush && bitIndex != '0) begin
                        // round a partial word up to whole bytes
                        validOutputBytes <= {1'b0, bitIndex[IDX_W-1:3]} + {2'b00, |bitIndex[2:0]};
                        resultReady      <= 1'b1;
                        state            <= stPresent;
                    end
                end
                stPresent: begin
                    if (readSuccess) begin
                        resultReady <= 1'b0;
                        out         <= '0;    // unused bits of the next word stay zero
                        bitIndex    <= '0;
                        state       <= stRelease;
                    end
                end
                stRelease: begin
                    if (!readSuccess) begin
                        state <= stCollect;
                    end
                end
                default: state <= stCollect;
            endcase
        end
    end

endmodule

// ==== hdl/subintervalCalc.sv ====
// calcDone follows calcStart by 2*DIVIDEND_W+3 cycles; a new calcStart is ignored until then
module subintervalCalc #(
    parameter int PRECISION = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 calcStart,
    input  logic [PRECISION-1:0] width,
    input  arithCodePkg::symbolT curSymbol,
    output logic [PRECISION-1:0] lowOffset,
    output logic [PRECISION-1:0] highOffset,
    output logic                 calcDone
);
    import arithCodePkg::*;

    localparam int DIVIDEND_W = productW(PRECISION);
    localparam int DIVISOR_W = FREQ_W;

    typedef enum logic [1:0] {
        stIdle,
        stDivHigh,
        stDivLow
    } stateT;

    stateT                 state;
    logic [DIVIDEND_W-1:0] highProd;
    logic [DIVIDEND_W-1:0] lowProd;
    logic [DIVIDEND_W-1:0] dividend;
    logic [DIVIDEND_W-1:0] quotient;
    logic [DIVISOR_W-1:0]  divisor;
    logic                  divStart;
    logic                  divDone;

    assign dividend = (state == stDivLow) ? lowProd : highProd;
    assign divisor  = DIVISOR_W'(TOTAL_FREQ);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= stIdle;
            divStart <= 1'b0;
            calcDone <= 1'b0;
        end else begin
            divStart <= 1'b0;
            calcDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (calcStart) begin
                        divStart <= 1'b1;    // products are ready next cycle
                        state    <= stDivHigh;
                    end
                end
                stDivHigh: begin
                    if (divDone) begin
                        divStart <= 1'b1;
                        state    <= stDivLow;
                    end
                end
                stDivLow: begin
                    if (divDone) begin
                        calcDone <= 1'b1;
                        state    <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && calcStart) begin
            highProd <= width * CUM_HIGH[curSymbol];
            lowProd  <= width * CUM_LOW[curSymbol];
        end
        if (state == stDivHigh && divDone) begin
            highOffset <= quotient[PRECISION-1:0];    // never above width
        end
        if (state == stDivLow && divDone) begin
            lowOffset <= quotient[PRECISION-1:0];
        end
    end

    seqDivider #(.DIVIDEND_W(DIVIDEND_W), .DIVISOR_W(DIVISOR_W)) divider (
        .clk(clk), .rstn(rstn), .divStart(divStart), .dividend(dividend),
        .divisor(divisor), .quotient(quotient), .divDone(divDone)
    );

endmodule

// ==== hdl/seqDivider.sv ====
// restoring divider for DIVIDEND_W of 2 or more and a nonzero divisor; starts while busy are dropped
module seqDivider #(
    parameter int DIVIDEND_W = 23,
    parameter int DIVISOR_W = 7
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  divStart,
    input  logic [DIVIDEND_W-1:0] dividend,
    input  logic [DIVISOR_W-1:0]  divisor,
    output logic [DIVIDEND_W-1:0] quotient,
    output logic                  divDone
);
    localparam int CNT_W = $clog2(DIVIDEND_W + 1);

    logic [DIVISOR_W-1:0]  remainder;
    logic [DIVIDEND_W-1:0] shiftReg;     // dividend bits leave at the top, quotient enters below
    logic [CNT_W-1:0]      bitCount;
    logic                  busy;
    logic                  load;
    logic [DIVIDEND_W-1:0] srcBits;
    logic [DIVISOR_W-1:0]  srcRem;
    logic [DIVISOR_W:0]    partial;
    logic [DIVISOR_W:0]    diff;

    assign load     = divStart && !busy;
    assign srcBits  = load ? dividend : shiftReg;    // first step runs on the start cycle
    assign srcRem   = load ? '0 : remainder;
    assign partial  = {srcRem, srcBits[DIVIDEND_W-1]};
    assign diff     = partial - {1'b0, divisor};
    assign quotient = shiftReg;

    always_ff @(posedge clk) begin
        if (load || busy) begin
            remainder <= diff[DIVISOR_W] ? partial[DIVISOR_W-1:0] : diff[DIVISOR_W-1:0];
            shiftReg  <= {srcBits[DIVIDEND_W-2:0], !diff[DIVISOR_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            divDone  <= 1'b0;
            bitCount <= '0;
        end else begin
            divDone <= 1'b0;
            if (load) begin
                busy     <= 1'b1;
                bitCount <= CNT_W'(DIVIDEND_W - 1);
            end else if (busy) begin
                bitCount <= bitCount - 1'b1;
                if (bitCount == CNT_W'(1)) begin
                    busy    <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/arithCodePkg.sv ====
// fixed 8-symbol model with symbol 7 as end of message; frequencies must sum to TOTAL_FREQ
package arithCodePkg;

    parameter int SYM_W       = 3;
    parameter int NUM_SYMBOLS = 8;
    parameter int FREQ_W      = 7;   // holds TOTAL_FREQ itself
    parameter int TOTAL_FREQ  = 64;
    parameter int WORD_W      = 32;

    typedef logic [SYM_W-1:0]  symbolT;
    typedef logic [WORD_W-1:0] wordT;

    parameter symbolT EOF_SYMBOL = 3'd7;

    // frequencies 12, 10, 9, 8, 8, 7, 6, 4
    parameter logic [FREQ_W-1:0] CUM_LOW [NUM_SYMBOLS] = '{
        7'd0, 7'd12, 7'd22, 7'd31, 7'd39, 7'd47, 7'd54, 7'd60
    };

    parameter logic [FREQ_W-1:0] CUM_HIGH [NUM_SYMBOLS] = '{
        7'd12, 7'd22, 7'd31, 7'd39, 7'd47, 7'd54, 7'd60, 7'd64
    };

    // width of interval width times a cumulative frequency
    function automatic int productW(int precision);
        return precision + FREQ_W;
    endfunction

    // pending counter width reaches far beyond any run of middle rescales
    function automatic int pendingW(int precision);
        return precision;
    endfunction

endpackage
